// ==== decode_top.f ====
+incdir+tb
hw/rv_decode_pkg.sv
hw/inst_queue.sv
hw/credit_counter.sv
hw/decode_fsm.sv
hw/id_control.sv
hw/imm_gen.sv
hw/decode_top.sv
tb/tb_decode.sv

// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - hw/rv_decode_pkg.sv
  - hw/inst_queue.sv
  - hw/credit_counter.sv
  - hw/decode_fsm.sv
  - hw/id_control.sv
  - hw/imm_gen.sv
  - hw/decode_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_decode.sv

// ==== tb/tb_decode_ref.svh ====
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// Expected decode of one instruction, given the instruction in execute
function automatic void ref_decode(input inst_t i, input inst_t ex, output imm_sel_t sel,
                                   output imm_t imm, output tgt_sel_t tgt, output logic fwd);
    logic reads;
    logic writes;
    case (i[6:2])
        OPC_ARI_ITYPE_5, OPC_JALR_5: sel = IMM_I;
        OPC_LOAD_5:   sel = (i[14:12] inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? IMM_I : IMM_NONE;
        OPC_STORE_5:  sel = (i[14:12] <= 3'd2) ? IMM_S : IMM_NONE;
        OPC_BRANCH_5: sel = (i[14:12] inside {3'd2, 3'd3}) ? IMM_NONE : IMM_B;
        OPC_JAL_5:    sel = IMM_J;
        OPC_LUI_5, OPC_AUIPC_5: sel = IMM_U;
        default:      sel = IMM_NONE;
    endcase
    case (sel)
        IMM_I:   imm = 32'($signed(i[31:20]));
        IMM_S:   imm = 32'($signed({i[31:25], i[11:7]}));
        IMM_B:   imm = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
        IMM_U:   imm = {i[31:12], 12'h000};
        IMM_J:   imm = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
        default: imm = '0;
    endcase
    case (i[6:2])
        OPC_BRANCH_5: tgt = TGT_BRANCH;
        OPC_JAL_5:    tgt = TGT_JAL;
        OPC_JALR_5:   tgt = TGT_JALR;
        default:      tgt = TGT_PC4;
    endcase
    // U and J formats have no rs1
    reads = i[6:2] inside {OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5, OPC_LOAD_5,
                           OPC_STORE_5, OPC_BRANCH_5, OPC_JALR_5};
    writes = ex[6:2] inside {OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5, OPC_LOAD_5, OPC_JAL_5,
                             OPC_JALR_5, OPC_LUI_5, OPC_AUIPC_5};
    fwd = reads && (i[19:15] != 5'd0) && writes && (ex[11:7] == i[19:15]);
endfunction

task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (exp !== act) begin
        value_errs++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_imm(input string name, input imm_t exp, input imm_t act);
    if (exp !== act) begin
        value_errs++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_imm_sel(input string name, input imm_sel_t exp, input imm_sel_t act);
    if (exp !== act) begin
        value_errs++;
        $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
endtask

task automatic check_tgt(input string name, input tgt_sel_t exp, input tgt_sel_t act);
    if (exp !== act) begin
        value_errs++;
        $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        value_errs++;
        $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

`endif

// ==== tb/tb_decode.sv ====
`timescale 1ns/100ps

module tb_decode;
    import rv_decode_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;

    typedef struct packed {
        inst_t    inst;
        imm_t     imm;
        imm_sel_t sel;
        tgt_sel_t tgt;
        logic     fwd;
    } exp_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     in_valid;
    inst_t    in_inst;
    logic     in_credit;
    inst_t    ex_inst;
    logic     stall;
    logic     flush;
    logic     out_credit;
    logic     out_valid;
    inst_t    out_inst;
    imm_t     out_imm;
    imm_sel_t out_imm_sel;
    tgt_sel_t out_target_gen_sel;
    logic     out_fwd_rs1;

    exp_t        sb[$];
    logic [31:0] stim_lfsr = 32'h357;
    logic [31:0] exec_lfsr = 32'h357;
    int          value_errs = 0;
    int          other_errs = 0;
    int          sent = 0;
    int          returned = 0;
    int          out_count = 0;
    int          ret_count = 0;
    int          ret_issued = 0;
    int          exec_gap = 0;
    int          cycles = 0;
    logic        withhold = 1'b0;
    logic        stall_prev = 1'b0;

    opcode5_t opc_tab [9] = '{OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5, OPC_LOAD_5, OPC_STORE_5,
                              OPC_BRANCH_5, OPC_JAL_5, OPC_JALR_5, OPC_LUI_5, OPC_AUIPC_5};
    // Words in execute are addi x5, lui x0, sw with imm field 5 and jal x7
    inst_t    ex_tab [4] = '{32'h0050_0293, 32'h0000_0037, 32'h0000_22a3, 32'h0000_03ef};
    int       rd_tab [4] = '{5, 0, 5, 7};

    `include "tb_decode_ref.svh"

    decode_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) dut0 (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (in_valid),
        .in_inst           (in_inst),
        .in_credit         (in_credit),
        .ex_inst           (ex_inst),
        .stall             (stall),
        .flush             (flush),
        .out_credit        (out_credit),
        .out_valid         (out_valid),
        .out_inst          (out_inst),
        .out_imm           (out_imm),
        .out_imm_sel       (out_imm_sel),
        .out_target_gen_sel(out_target_gen_sel),
        .out_fwd_rs1       (out_fwd_rs1)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Legal instruction of one class with rs1 forced unless the argument is negative
    function automatic inst_t gen_inst(input int kind, input int rs1);
        inst_t      w;
        logic [2:0] f3;
        w = take_bits(stim_lfsr, 32);
        f3 = w[14:12];
        w[6:0] = {opc_tab[kind], 2'b11};
        case (kind)
            0: w[31:25] = {1'b0, (f3 inside {3'd0, 3'd5}) & w[30], 5'b0};
            1: w[31:25] = (f3 == 3'd1) ? 7'h00 : (f3 == 3'd5) ? {1'b0, w[30], 5'b0} : w[31:25];
            2: w[14:12] = (f3 inside {3'd3, 3'd6, 3'd7}) ? 3'd2 : f3;
            3: w[14:12] = (f3 > 3'd2) ? 3'd2 : f3;
            4: w[14:12] = (f3 inside {3'd2, 3'd3}) ? 3'd0 : f3;
            6: w[14:12] = 3'd0;
            default: w = w;
        endcase
        if (rs1 >= 0) begin
            w[19:15] = rs1[4:0];
        end
        return w;
    endfunction

    // Fetch side sends one word per cycle while a credit is held
    task automatic send_inst(input inst_t w);
        imm_sel_t sel;
        imm_t     imm;
        tgt_sel_t tgt;
        logic     fwd;
        @(posedge clk);
        while (sent - returned >= QUEUE_DEPTH) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        ref_decode(w, ex_inst, sel, imm, tgt, fwd);
        in_valid <= 1'b1;
        in_inst  <= w;
        sent++;
        sb.push_back('{w, imm, sel, tgt, fwd});
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk);
            in_valid <= 1'b0;
        end while (sb.size() != 0);
    endtask

    // Execute returns each credit after a short random gap
    always @(posedge clk) begin
        if (reset) begin
            out_credit <= 1'b0;
        end else if (!withhold && (out_count - ret_issued > 0) && exec_gap == 0) begin
            out_credit <= 1'b1;
            ret_issued++;
            exec_gap = take_bits(exec_lfsr, 2);
        end else begin
            out_credit <= 1'b0;
            if (exec_gap > 0) begin
                exec_gap--;
            end
        end
    end

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        exp_t e;
        if (!reset) begin
            cycles++;
            if (in_credit) begin
                if (sent - returned <= 0) begin
                    other_errs++;
                    $display("in_credit arrived while fetch already held all its credits");
                end
                returned++;
            end
            if (out_valid) begin
                out_count++;
                if (stall_prev) begin
                    other_errs++;
                    $display("out_valid appeared at %0t ns while stall was high", $time);
                end
                if (out_count > OUT_CREDITS + ret_count) begin
                    other_errs++;
                    $display("More out_valid cycles than downstream credits at %0t ns", $time);
                end
                if (sb.size() == 0) begin
                    other_errs++;
                    $display("out_valid at %0t ns with no instruction expected", $time);
                end else begin
                    e = sb.pop_front();
                    check_inst("out_inst", e.inst, out_inst);
                    check_imm("out_imm", e.imm, out_imm);
                    check_imm_sel("out_imm_sel", e.sel, out_imm_sel);
                    check_tgt("out_target_gen_sel", e.tgt, out_target_gen_sel);
                    check_bit("out_fwd_rs1", e.fwd, out_fwd_rs1);
                end
            end
            if (out_credit) begin
                ret_count++;
            end
            stall_prev = stall;
        end
    end

    initial begin
        wait (cycles > 40 * sent + 200);
        $display("Timeout after %0d cycles with %0d instructions sent", cycles, sent);
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int mark;
        int drained;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_inst    = '0;
        ex_inst    = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        out_credit = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
            other_errs++;
            $display("out_valid or in_credit not low after reset");
        end

        // All opcode classes
        for (int n = 0; n < 54; n++) begin
            send_inst(gen_inst(n % 9, -1));
        end
        wait_drained();

        // Forwarding with ex_inst changed only while the queue is empty
        for (int s = 0; s < 4; s++) begin
            ex_inst <= ex_tab[s];
            for (int n = 0; n < 18; n++) begin
                send_inst(gen_inst(n % 9, (n % 2 == 1) ? rd_tab[s] : -1));
            end
            wait_drained();
        end

        // Execute withholds credits
        withhold <= 1'b1;
        fork
            for (int n = 0; n < 12; n++) begin
                send_inst(gen_inst(n % 9, -1));
            end
            begin
                repeat (80) @(posedge clk);
                withhold <= 1'b0;
            end
        join
        wait_drained();

        stall <= 1'b1;
        for (int n = 0; n < QUEUE_DEPTH; n++) begin
            send_inst(gen_inst(n + 2, -1));
        end
        idle(20);
        stall <= 1'b0;
        wait_drained();

        // Fill under stall and then flush
        stall <= 1'b1;
        for (int n = 0; n < QUEUE_DEPTH; n++) begin
            send_inst(gen_inst(n + 4, -1));
        end
        idle(5);
        stall <= 1'b0;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        mark = returned;
        while (sent != returned) begin
            idle(1);
        end
        drained = sb.size();
        if (drained != QUEUE_DEPTH || returned - mark != drained) begin
            other_errs++;
            $display("Flush discarded %0d entries with %0d in_credit pulses", drained,
                     returned - mark);
        end
        sb.delete();

        for (int n = 0; n < 18; n++) begin
            send_inst(gen_inst(n % 9, -1));
        end
        wait_drained();
        idle(10);
        if (sent != returned) begin
            other_errs++;
            $display("Fetch credits not restored, %0d still out", sent - returned);
        end
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hw/decode_top.sv ====
`timescale 1ns/100ps

module decode_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  rv_decode_pkg::inst_t    in_inst,
    output logic                    in_credit,
    input  rv_decode_pkg::inst_t    ex_inst,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    out_credit,
    output logic                    out_valid,
    output rv_decode_pkg::inst_t    out_inst,
    output rv_decode_pkg::imm_t     out_imm,
    output rv_decode_pkg::imm_sel_t out_imm_sel,
    output rv_decode_pkg::tgt_sel_t out_target_gen_sel,
    output logic                    out_fwd_rs1
);
    import rv_decode_pkg::*;

    inst_t    head_inst;
    logic     empty;
    logic     has_credit;
    logic     pop_issue;
    logic     pop_drain;
    logic     pop_any;
    imm_sel_t imm_sel;
    tgt_sel_t target_gen_sel;
    logic     fwd_rs1;

    // Issue and drain both free a queue entry
    assign pop_any = pop_issue | pop_drain;

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (in_valid),
        .wr_inst  (in_inst),
        .pop      (pop_any),
        .head_inst(head_inst),
        .empty    (empty)
    );

    credit_counter #(
        .OUT_CREDITS(OUT_CREDITS)
    ) u_credits (
        .clk       (clk),
        .reset     (reset),
        .spend     (pop_issue),
        .refund    (out_credit),
        .freed     (pop_any),
        .has_credit(has_credit),
        .in_credit (in_credit)
    );

    decode_fsm u_fsm (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .empty     (empty),
        .has_credit(has_credit),
        .in_valid  (in_valid),
        .pop_issue (pop_issue),
        .pop_drain (pop_drain)
    );

    id_control u_ctrl (
        .inst          (head_inst),
        .ex_inst       (ex_inst),
        .imm_sel       (imm_sel),
        .target_gen_sel(target_gen_sel),
        .fwd_rs1       (fwd_rs1)
    );

    imm_gen u_imm (
        .clk               (clk),
        .reset             (reset),
        .issue             (pop_issue),
        .inst              (head_inst),
        .imm_sel           (imm_sel),
        .target_gen_sel    (target_gen_sel),
        .fwd_rs1           (fwd_rs1),
        .out_valid         (out_valid),
        .out_inst          (out_inst),
        .out_imm           (out_imm),
        .out_imm_sel       (out_imm_sel),
        .out_target_gen_sel(out_target_gen_sel),
        .out_fwd_rs1       (out_fwd_rs1)
    );

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue,
    input  rv_decode_pkg::inst_t    inst,
    input  rv_decode_pkg::imm_sel_t imm_sel,
    input  rv_decode_pkg::tgt_sel_t target_gen_sel,
    input  logic                    fwd_rs1,
    output logic                    out_valid,
    output rv_decode_pkg::inst_t    out_inst,
    output rv_decode_pkg::imm_t     out_imm,
    output rv_decode_pkg::imm_sel_t out_imm_sel,
    output rv_decode_pkg::tgt_sel_t out_target_gen_sel,
    output logic                    out_fwd_rs1
);
    import rv_decode_pkg::*;

    imm_t imm;

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = {{20{inst[31]}}, inst[31:20]};
            IMM_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {inst[31:12], 12'b0};
            IMM_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_inst           <= inst;
            out_imm            <= imm;
            out_imm_sel        <= imm_sel;
            out_target_gen_sel <= target_gen_sel;
            out_fwd_rs1        <= fwd_rs1;
        end
    end

endmodule

// ==== hw/id_control.sv ====
`timescale 1ns/100ps

module id_control (
    input  rv_decode_pkg::inst_t    inst,
    input  rv_decode_pkg::inst_t    ex_inst,
    output rv_decode_pkg::imm_sel_t imm_sel,
    output rv_decode_pkg::tgt_sel_t target_gen_sel,
    output logic                    fwd_rs1
);
    import rv_decode_pkg::*;

    opcode5_t opcode5;
    funct3_t  funct3;
    reg_idx_t rs1;
    opcode5_t ex_opcode5;
    reg_idx_t ex_rd;
    logic     reads_rs1;
    logic     ex_writes_rd;

    assign opcode5    = inst[6:2];
    assign funct3     = inst[14:12];
    assign rs1        = inst[19:15];
    assign ex_opcode5 = ex_inst[6:2];
    assign ex_rd      = ex_inst[11:7];

    // Immediate format per opcode, unknown funct3 falls back to none
    always_comb begin
        imm_sel = IMM_NONE;
        case (opcode5)
            OPC_ARI_ITYPE_5: imm_sel = IMM_I;
            OPC_JALR_5:      imm_sel = IMM_I;
            OPC_LOAD_5: begin
                case (funct3)
                    FNC_LB, FNC_LH, FNC_LW, FNC_LBU, FNC_LHU: imm_sel = IMM_I;
                    default: imm_sel = IMM_NONE;
                endcase
            end
            OPC_STORE_5: begin
                case (funct3)
                    FNC_SB, FNC_SH, FNC_SW: imm_sel = IMM_S;
                    default: imm_sel = IMM_NONE;
                endcase
            end
            OPC_BRANCH_5: begin
                case (funct3)
                    FNC_BEQ, FNC_BNE, FNC_BLT, FNC_BGE, FNC_BLTU, FNC_BGEU: imm_sel = IMM_B;
                    default: imm_sel = IMM_NONE;
                endcase
            end
            OPC_JAL_5:   imm_sel = IMM_J;
            OPC_LUI_5:   imm_sel = IMM_U;
            OPC_AUIPC_5: imm_sel = IMM_U;
            default:     imm_sel = IMM_NONE;
        endcase
    end

    always_comb begin
        case (opcode5)
            OPC_BRANCH_5: target_gen_sel = TGT_BRANCH;
            OPC_JAL_5:    target_gen_sel = TGT_JAL;
            OPC_JALR_5:   target_gen_sel = TGT_JALR;
            default:      target_gen_sel = TGT_PC4;
        endcase
    end

    always_comb begin
        case (opcode5)
            OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5, OPC_LOAD_5,
            OPC_STORE_5, OPC_BRANCH_5, OPC_JALR_5: reads_rs1 = 1'b1;
            default: reads_rs1 = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_opcode5)
            OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5, OPC_LOAD_5, OPC_JAL_5,
            OPC_JALR_5, OPC_LUI_5, OPC_AUIPC_5: ex_writes_rd = 1'b1;
            default: ex_writes_rd = 1'b0;
        endcase
    end

    // x0 never forwards
    assign fwd_rs1 = reads_rs1 && (rs1 != '0) && ex_writes_rd && (ex_rd == rs1);

endmodule

// ==== hw/decode_fsm.sv ====
`timescale 1ns/100ps

module decode_fsm (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flush,
    input  logic empty,
    input  logic has_credit,
    input  logic in_valid,
    output logic pop_issue,
    output logic pop_drain
);
    import rv_decode_pkg::*;

    decode_state_t state;
    decode_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RUN;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        pop_issue  = 1'b0;
        pop_drain  = 1'b0;
        case (state)
            ST_RUN: begin
                if (flush) begin
                    state_next = ST_DRAIN;
                end else if (stall || (!empty && !has_credit)) begin
                    state_next = ST_HOLD;
                end else if (!empty) begin
                    pop_issue = 1'b1;
                end
            end
            ST_HOLD: begin
                // Resume one cycle after the blocking condition clears
                if (flush) begin
                    state_next = ST_DRAIN;
                end else if (!stall && has_credit) begin
                    state_next = ST_RUN;
                end
            end
            ST_DRAIN: begin
                pop_drain = !empty;
                // Late writes from fetch are drained too
                if (!flush && empty && !in_valid) begin
                    state_next = ST_RUN;
                end
            end
            default: begin
                state_next = ST_RUN;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0({pop_issue, pop_drain}))
        else $error("decode_fsm: issue and drain in the same cycle");

endmodule

// ==== hw/credit_counter.sv ====
`timescale 1ns/100ps

module credit_counter #(
    parameter int OUT_CREDITS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic spend,
    input  logic refund,
    input  logic freed,
    output logic has_credit,
    output logic in_credit
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] count;

    assign has_credit = (count != '0);

    // Downstream credits on hand
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({refund, spend})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back to fetch per freed entry
    always_ff @(posedge clk) begin
        if (reset) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= freed;
        end
    end

    // Execute never returns more than it was given
    assert property (@(posedge clk) disable iff (reset)
        !(refund && !spend && count == CNT_W'(OUT_CREDITS)))
        else $error("credit_counter: credit overflow");

    assert property (@(posedge clk) disable iff (reset) !(spend && count == '0))
        else $error("credit_counter: credit underflow");

endmodule

// ==== hw/inst_queue.sv ====
`timescale 1ns/100ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  rv_decode_pkg::inst_t wr_inst,
    input  logic                 pop,
    output rv_decode_pkg::inst_t head_inst,
    output logic                 empty
);
    import rv_decode_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    inst_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    // Wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(QUEUE_DEPTH));
    assign head_inst = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Fetch only writes while it holds a credit
    assert property (@(posedge clk) disable iff (reset) !(wr_en && full))
        else $error("inst_queue: write while full");

    assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("inst_queue: pop while empty");

endmodule

// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] imm_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  opcode5_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  imm_sel_t;
    typedef logic [1:0]  tgt_sel_t;

    // Major opcodes, bits 6 to 2 of the instruction
    localparam opcode5_t OPC_ARI_RTYPE_5 = 5'b01100;
    localparam opcode5_t OPC_ARI_ITYPE_5 = 5'b00100;
    localparam opcode5_t OPC_LOAD_5      = 5'b00000;
    localparam opcode5_t OPC_STORE_5     = 5'b01000;
    localparam opcode5_t OPC_BRANCH_5    = 5'b11000;
    localparam opcode5_t OPC_JAL_5       = 5'b11011;
    localparam opcode5_t OPC_JALR_5      = 5'b11001;
    localparam opcode5_t OPC_LUI_5       = 5'b01101;
    localparam opcode5_t OPC_AUIPC_5     = 5'b00101;

    // Load widths
    localparam funct3_t FNC_LB  = 3'b000;
    localparam funct3_t FNC_LH  = 3'b001;
    localparam funct3_t FNC_LW  = 3'b010;
    localparam funct3_t FNC_LBU = 3'b100;
    localparam funct3_t FNC_LHU = 3'b101;

    // Store widths
    localparam funct3_t FNC_SB = 3'b000;
    localparam funct3_t FNC_SH = 3'b001;
    localparam funct3_t FNC_SW = 3'b010;

    // Branch conditions
    localparam funct3_t FNC_BEQ  = 3'b000;
    localparam funct3_t FNC_BNE  = 3'b001;
    localparam funct3_t FNC_BLT  = 3'b100;
    localparam funct3_t FNC_BGE  = 3'b101;
    localparam funct3_t FNC_BLTU = 3'b110;
    localparam funct3_t FNC_BGEU = 3'b111;

    // Immediate formats, NONE gives a zero immediate
    localparam imm_sel_t IMM_NONE = 3'd0;
    localparam imm_sel_t IMM_I    = 3'd1;
    localparam imm_sel_t IMM_S    = 3'd2;
    localparam imm_sel_t IMM_B    = 3'd3;
    localparam imm_sel_t IMM_U    = 3'd4;
    localparam imm_sel_t IMM_J    = 3'd5;

    // Next-PC source
    localparam tgt_sel_t TGT_PC4    = 2'd0;
    localparam tgt_sel_t TGT_BRANCH = 2'd1;
    localparam tgt_sel_t TGT_JAL    = 2'd2;
    localparam tgt_sel_t TGT_JALR   = 2'd3;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_HOLD,
        ST_DRAIN
    } decode_state_t;

endpackage
